// File: Makefile
TOP = dbgmem_tb
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: project.f
src/dbgmem_cfg_pkg.sv
src/dbgmem_types_pkg.sv
src/sync_fifo.sv
src/req_sequencer.sv
src/debug_ram.sv
src/rsp_aligner.sv
src/dbgmem_top.sv
verification/dbgmem_tb.sv

// File: src/dbgmem_cfg_pkg.sv
package dbgmem_cfg_pkg;

  // Memory word and byte-enable widths
  localparam int data_w = 64;
  localparam int be_w   = 8;

  // 1024 words
  localparam int addr_w = 10;

  // Defaults picked up by the top level parameters
  localparam int def_mem_latency  = 3;
  localparam int def_host_latency = 12;
  localparam int def_fifo_depth   = 16;

endpackage

// File: src/dbgmem_top.sv
`timescale 1ns/1ps

module dbgmem_top #(
  parameter int MEM_LATENCY  = dbgmem_cfg_pkg::def_mem_latency,
  parameter int HOST_LATENCY = dbgmem_cfg_pkg::def_host_latency,
  parameter int FIFO_DEPTH   = dbgmem_cfg_pkg::def_fifo_depth
) (
  input  logic                              dbg_clk,
  input  logic                              dbg_rst,
  input  logic                              host_en,
  input  dbgmem_types_pkg::mem_req_t        host_req,
  output logic [dbgmem_cfg_pkg::data_w-1:0] host_dout,
  output logic                              host_dout_valid,
  input  logic                              dbg_en,
  input  dbgmem_types_pkg::mem_req_t        dbg_req,
  output logic [dbgmem_cfg_pkg::data_w-1:0] dbg_dout
);

  import dbgmem_cfg_pkg::*;
  import dbgmem_types_pkg::*;

  localparam int REQ_W = $bits(mem_req_t);

  mem_req_t          q_head;
  logic              q_empty;
  logic              fifo_pop;
  logic              port_a_en;
  mem_req_t          port_a_req;
  logic              rd_issue;
  logic [data_w-1:0] port_a_dout;

  // Host requests wait here for the sequencer
  sync_fifo #(
    .WIDTH (REQ_W),
    .DEPTH (FIFO_DEPTH)
  ) req_fifo_inst (
    .dbg_clk   (dbg_clk),
    .dbg_rst   (dbg_rst),
    .push      (host_en),
    .push_data (host_req),
    .pop       (fifo_pop),
    .head      (q_head),
    .empty     (q_empty),
    .full      ()
  );

  req_sequencer req_sequencer_inst (
    .dbg_clk    (dbg_clk),
    .dbg_rst    (dbg_rst),
    .q_head     (q_head),
    .q_empty    (q_empty),
    .fifo_pop   (fifo_pop),
    .port_a_en  (port_a_en),
    .port_a_req (port_a_req),
    .rd_issue   (rd_issue)
  );

  // Port A serves the host, port B is the direct debug path
  debug_ram #(
    .MEM_LATENCY (MEM_LATENCY)
  ) debug_ram_inst (
    .dbg_clk (dbg_clk),
    .a_en    (port_a_en),
    .a_req   (port_a_req),
    .a_dout  (port_a_dout),
    .b_en    (dbg_en),
    .b_req   (dbg_req),
    .b_dout  (dbg_dout)
  );

  rsp_aligner #(
    .MEM_LATENCY  (MEM_LATENCY),
    .HOST_LATENCY (HOST_LATENCY),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) rsp_aligner_inst (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .rd_issue        (rd_issue),
    .a_dout          (port_a_dout),
    .host_en         (host_en),
    .host_we         (host_req.we),
    .host_dout       (host_dout),
    .host_dout_valid (host_dout_valid)
  );

endmodule

// File: src/dbgmem_types_pkg.sv
package dbgmem_types_pkg;

  import dbgmem_cfg_pkg::*;

  // One memory access, a zero byte mask means a read
  typedef struct packed {
    logic [be_w-1:0]   we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] din;
  } mem_req_t;

  // Request sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_SETTLE
  } seq_state_t;

endpackage

// File: src/debug_ram.sv
`timescale 1ns/1ps

module debug_ram #(
  parameter int MEM_LATENCY = dbgmem_cfg_pkg::def_mem_latency
) (
  input  logic                              dbg_clk,
  input  logic                              a_en,
  input  dbgmem_types_pkg::mem_req_t        a_req,
  output logic [dbgmem_cfg_pkg::data_w-1:0] a_dout,
  input  logic                              b_en,
  input  dbgmem_types_pkg::mem_req_t        b_req,
  output logic [dbgmem_cfg_pkg::data_w-1:0] b_dout
);

  import dbgmem_cfg_pkg::*;
  import dbgmem_types_pkg::*;

  localparam int NUM_PORTS = 2;
  localparam int BYTE_W    = data_w / be_w;
  // Input register takes one cycle, the output pipeline the rest
  localparam int STAGES    = MEM_LATENCY - 1;

  logic [data_w-1:0] mem [2**addr_w];
  logic              en_q [NUM_PORTS];
  mem_req_t          req_q [NUM_PORTS];
  logic [data_w-1:0] rd_pipe [NUM_PORTS][STAGES];

  always_ff @(posedge dbg_clk) begin
    en_q[0]  <= a_en;
    req_q[0] <= a_req;
    en_q[1]  <= b_en;
    req_q[1] <= b_req;
  end

  // Both ports share one process so the array has a single writer
  always_ff @(posedge dbg_clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (en_q[p]) begin
        for (int b = 0; b < be_w; b++) begin
          if (req_q[p].we[b]) begin
            mem[req_q[p].addr][b*BYTE_W +: BYTE_W] <= req_q[p].din[b*BYTE_W +: BYTE_W];
          end
        end
        // First stage loads only on reads, so the whole pipe holds between reads
        if (req_q[p].we == '0) begin
          rd_pipe[p][0] <= mem[req_q[p].addr];
        end
      end
      for (int s = 1; s < STAGES; s++) begin
        rd_pipe[p][s] <= rd_pipe[p][s-1];
      end
    end
  end

  assign a_dout = rd_pipe[0][STAGES-1];
  assign b_dout = rd_pipe[1][STAGES-1];

  // Host and debug sides must not write one word in the same cycle
  a_no_write_collision: assert property (@(posedge dbg_clk)
    !(a_en && b_en && (a_req.we != '0) && (b_req.we != '0) && (a_req.addr == b_req.addr)))
    else $error("debug_ram: both ports write the same address");

endmodule

// File: src/req_sequencer.sv
`timescale 1ns/1ps

module req_sequencer (
  input  logic                       dbg_clk,
  input  logic                       dbg_rst,
  input  dbgmem_types_pkg::mem_req_t q_head,
  input  logic                       q_empty,
  output logic                       fifo_pop,
  output logic                       port_a_en,
  output dbgmem_types_pkg::mem_req_t port_a_req,
  output logic                       rd_issue
);

  import dbgmem_types_pkg::*;

  seq_state_t state;
  logic       q_empty_q;
  mem_req_t   q_head_q;
  logic       issue;

  // Queue outputs are registered once before they steer the FSM
  always_ff @(posedge dbg_clk) begin
    q_head_q <= q_head;
  end

  assign issue = (state == SEQ_IDLE) && !q_empty_q;

  always_ff @(posedge dbg_clk) begin
    if (dbg_rst) begin
      q_empty_q <= 1'b1;
      state     <= SEQ_IDLE;
      fifo_pop  <= 1'b0;
      port_a_en <= 1'b0;
      rd_issue  <= 1'b0;
    end else begin
      q_empty_q <= q_empty;
      fifo_pop  <= 1'b0;
      port_a_en <= 1'b0;
      rd_issue  <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (issue) begin
            fifo_pop  <= 1'b1;
            port_a_en <= 1'b1;
            rd_issue  <= (q_head_q.we == '0);
            state     <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: state <= SEQ_SETTLE;
        // Gives the pop time to reach the registered empty flag
        SEQ_SETTLE: state <= SEQ_IDLE;
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge dbg_clk) begin
    if (issue) begin
      port_a_req <= q_head_q;
    end
  end

  // On the idle exit the queue must still hold the request being issued
  a_issue_matches_head: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    port_a_en |-> !q_empty && (port_a_req == q_head))
    else $error("req_sequencer: issued request does not match the queue head");

endmodule

// File: src/rsp_aligner.sv
`timescale 1ns/1ps

module rsp_aligner #(
  parameter int MEM_LATENCY  = dbgmem_cfg_pkg::def_mem_latency,
  parameter int HOST_LATENCY = dbgmem_cfg_pkg::def_host_latency,
  parameter int FIFO_DEPTH   = dbgmem_cfg_pkg::def_fifo_depth
) (
  input  logic                              dbg_clk,
  input  logic                              dbg_rst,
  input  logic                              rd_issue,
  input  logic [dbgmem_cfg_pkg::data_w-1:0] a_dout,
  input  logic                              host_en,
  input  logic [dbgmem_cfg_pkg::be_w-1:0]   host_we,
  output logic [dbgmem_cfg_pkg::data_w-1:0] host_dout,
  output logic                              host_dout_valid
);

  import dbgmem_cfg_pkg::*;

  // Worst case the read data lands in the queue in cycle MEM_LATENCY + 3
  if (HOST_LATENCY < MEM_LATENCY + 5) begin : g_latency_check
    $error("rsp_aligner: HOST_LATENCY must be at least MEM_LATENCY + 5");
  end

  logic [MEM_LATENCY-1:0]  rd_sr;
  logic [HOST_LATENCY-2:0] host_rd_sr;
  logic                    host_rd;
  logic                    rsp_push;
  logic                    rsp_pop;
  logic                    rsp_empty;
  logic [data_w-1:0]       rsp_head;

  assign host_rd  = host_en && (host_we == '0);
  assign rsp_push = rd_sr[MEM_LATENCY-1];
  // Pop one cycle early since host_dout is registered
  assign rsp_pop  = host_rd_sr[HOST_LATENCY-2];

  always_ff @(posedge dbg_clk) begin
    if (dbg_rst) begin
      rd_sr           <= '0;
      host_rd_sr      <= '0;
      host_dout_valid <= 1'b0;
    end else begin
      rd_sr           <= {rd_sr[MEM_LATENCY-2:0], rd_issue};
      host_rd_sr      <= {host_rd_sr[HOST_LATENCY-3:0], host_rd};
      host_dout_valid <= rsp_pop;
    end
  end

  always_ff @(posedge dbg_clk) begin
    if (rsp_pop) begin
      host_dout <= rsp_head;
    end
  end

  sync_fifo #(
    .WIDTH (data_w),
    .DEPTH (FIFO_DEPTH)
  ) rsp_fifo_inst (
    .dbg_clk   (dbg_clk),
    .dbg_rst   (dbg_rst),
    .push      (rsp_push),
    .push_data (a_dout),
    .pop       (rsp_pop),
    .head      (rsp_head),
    .empty     (rsp_empty),
    .full      ()
  );

  // Read data must have made it through the sequencer and RAM by now
  a_rsp_ready: assert property (@(posedge dbg_clk) disable iff (dbg_rst) rsp_pop |-> !rsp_empty)
    else $error("rsp_aligner: response missing at host latency");

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             dbg_clk,
  input  logic             dbg_rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] buf_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Pointer increment with wrap for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // Show-ahead, oldest entry is always on the head
  assign head = buf_mem[rd_ptr];

  always_ff @(posedge dbg_clk) begin
    if (do_push) begin
      buf_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge dbg_clk) begin
    if (dbg_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The producers have no back-pressure, so these must never fire
  a_no_overflow: assert property (@(posedge dbg_clk) disable iff (dbg_rst) push |-> !full)
    else $error("sync_fifo: push while full");
  a_no_underflow: assert property (@(posedge dbg_clk) disable iff (dbg_rst) pop |-> !empty)
    else $error("sync_fifo: pop while empty");

endmodule

// File: verification/dbgmem_tb.sv
`timescale 1ns/1ps

module dbgmem_tb;

  import dbgmem_cfg_pkg::*;
  import dbgmem_types_pkg::*;

  localparam int drain_limit = 500;

  logic              dbg_clk;
  logic              dbg_rst;
  logic              host_en;
  mem_req_t          host_req;
  logic [data_w-1:0] host_dout;
  logic              host_dout_valid;
  logic              dbg_en;
  mem_req_t          dbg_req;
  logic [data_w-1:0] dbg_dout;

  // Reference memory and expected words in issue order
  logic [data_w-1:0] ref_mem [2**addr_w];
  logic [data_w-1:0] exp_host [$];
  logic [data_w-1:0] exp_dbg [$];
  int                host_rd_cyc [$];

  integer                     seed = 60;
  int                         cyc = 0;
  int                         n_checks = 0;
  int                         n_err = 0;
  int                         n_host_rd = 0;
  int                         n_valid = 0;
  int                         test_err0 = 0;
  int                         rd_cyc;
  int                         valid_before;
  logic [def_mem_latency-1:0] dbg_rd_sr;
  logic [data_w-1:0]          exp_w;
  logic [data_w-1:0]          last_dbg_w;
  logic                       last_dbg_seen;

  dbgmem_top dbgmem_top_inst (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .host_en         (host_en),
    .host_req        (host_req),
    .host_dout       (host_dout),
    .host_dout_valid (host_dout_valid),
    .dbg_en          (dbg_en),
    .dbg_req         (dbg_req),
    .dbg_dout        (dbg_dout)
  );

  always #10 dbg_clk = ~dbg_clk;

  // Expected word after a byte-masked write
  function automatic logic [data_w-1:0] ref_merge(input logic [data_w-1:0] old_w,
                                                  input logic [data_w-1:0] new_w,
                                                  input logic [be_w-1:0]   mask);
    logic [data_w-1:0] res;
    res = old_w;
    for (int i = 0; i < be_w; i++) begin
      if (mask[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
    return {{6{a}}, 4'h9};
  endfunction

  // One host access, then two quiet cycles to keep the three-cycle spacing
  task automatic host_op(input logic [be_w-1:0] we, input logic [addr_w-1:0] addr,
                         input logic [data_w-1:0] din);
    mem_req_t req;
    req.we   = we;
    req.addr = addr;
    req.din  = din;
    @(posedge dbg_clk);
    host_en  <= 1'b1;
    host_req <= req;
    if (we == '0) begin
      exp_host.push_back(ref_mem[addr]);
      n_host_rd++;
    end else begin
      ref_mem[addr] = ref_merge(ref_mem[addr], din, we);
    end
    @(posedge dbg_clk);
    host_en <= 1'b0;
    @(posedge dbg_clk);
  endtask

  task automatic debug_op(input logic [be_w-1:0] we, input logic [addr_w-1:0] addr,
                          input logic [data_w-1:0] din);
    mem_req_t req;
    req.we   = we;
    req.addr = addr;
    req.din  = din;
    @(posedge dbg_clk);
    dbg_en  <= 1'b1;
    dbg_req <= req;
    if (we == '0) begin
      exp_dbg.push_back(ref_mem[addr]);
    end else begin
      ref_mem[addr] = ref_merge(ref_mem[addr], din, we);
    end
    @(posedge dbg_clk);
    dbg_en <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge dbg_clk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_host.size() != 0 || exp_dbg.size() != 0) && waited < drain_limit) begin
      @(posedge dbg_clk);
      waited++;
    end
    if (exp_host.size() != 0 || exp_dbg.size() != 0) begin
      $display("Timeout: reads still outstanding after %0d cycles", drain_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  endtask

  task automatic random_ops(input int n);
    logic [31:0]       rnd;
    logic [31:0]       rnd_hi;
    logic [31:0]       rnd_lo;
    logic [be_w-1:0]   mask;
    logic [addr_w-1:0] addr;
    for (int i = 0; i < n; i++) begin
      rnd    = $random(seed);
      rnd_hi = $random(seed);
      rnd_lo = $random(seed);
      mask   = rnd[1] ? '0 : rnd[15:8];
      if (!rnd[1] && mask == '0) begin
        mask = 8'h01;
      end
      // Host side keeps to the lower half, debug side to the upper half
      addr = {!rnd[0], rnd[24:16]};
      if (rnd[0]) begin
        host_op(mask, addr, {rnd_hi, rnd_lo});
      end else begin
        debug_op(mask, addr, {rnd_hi, rnd_lo});
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d (%s) finished with %0d errors", num, name, n_err - test_err0);
    test_err0 = n_err;
  endtask

  // Outputs are compared mid-cycle on the falling edge
  always @(negedge dbg_clk) begin
    if (dbg_rst) begin
      cyc           = 0;
      dbg_rd_sr     = '0;
      last_dbg_seen = 1'b0;
    end else begin
      cyc++;
      if (host_en && host_req.we == '0) begin
        host_rd_cyc.push_back(cyc);
      end
      if (host_dout_valid) begin
        n_valid++;
        if (exp_host.size() == 0 || host_rd_cyc.size() == 0) begin
          $display("Error: host_dout_valid pulsed with no host read outstanding");
          n_err++;
        end else begin
          exp_w  = exp_host.pop_front();
          rd_cyc = host_rd_cyc.pop_front();
          n_checks++;
          if (host_dout !== exp_w) begin
            $display("FAIL host_dout: expected %h, got %h", exp_w, host_dout);
            n_err++;
          end
          if (cyc - rd_cyc != def_host_latency) begin
            $display("FAIL host_dout_valid latency: expected %h, got %h",
                     def_host_latency, cyc - rd_cyc);
            n_err++;
          end
        end
      end
      // Debug read issued MEM_LATENCY cycles ago
      if (dbg_rd_sr[def_mem_latency-1]) begin
        if (exp_dbg.size() == 0) begin
          $display("Error: debug read completed with no expected word queued");
          n_err++;
        end else begin
          exp_w = exp_dbg.pop_front();
          n_checks++;
          if (dbg_dout !== exp_w) begin
            $display("FAIL dbg_dout: expected %h, got %h", exp_w, dbg_dout);
            n_err++;
          end
          last_dbg_w    = exp_w;
          last_dbg_seen = 1'b1;
        end
      end
      // One cycle early the port still holds the previous read
      if (dbg_rd_sr[def_mem_latency-2] && last_dbg_seen) begin
        n_checks++;
        if (dbg_dout !== last_dbg_w) begin
          $display("FAIL dbg_dout: early change, expected %h, got %h", last_dbg_w, dbg_dout);
          n_err++;
        end
      end
      dbg_rd_sr = {dbg_rd_sr[def_mem_latency-2:0], dbg_en && (dbg_req.we == '0)};
    end
  end

  initial begin
    dbg_clk  = 1'b0;
    dbg_rst  = 1'b1;
    host_en  = 1'b0;
    host_req = '0;
    dbg_en   = 1'b0;
    dbg_req  = '0;
    repeat (10) @(posedge dbg_clk);
    dbg_rst <= 1'b0;

    idle(20);
    if (n_valid != 0) begin
      $display("Error: host_dout_valid pulsed %0d times with no requests", n_valid);
      n_err++;
    end
    end_test(1, "quiet after reset");

    // Fill every word so later reads never see unwritten data
    for (int a = 0; a < 2**addr_w; a++) begin
      debug_op(8'hff, addr_w'(a), fill_word(addr_w'(a)));
    end
    debug_op(8'hff, 10'd17, 64'h0123_4567_89ab_cdef);
    debug_op(8'hff, 10'd600, 64'hdead_beef_0bad_f00d);
    debug_op(8'h00, 10'd0, '0);
    debug_op(8'h00, 10'd17, '0);
    debug_op(8'h00, 10'd341, '0);
    debug_op(8'h00, 10'd600, '0);
    debug_op(8'h00, 10'd1023, '0);
    wait_drain();
    end_test(2, "debug write and read");

    for (int i = 0; i < 6; i++) begin
      host_op(8'hff, addr_w'(40 + 7 * i), {32'h5eed_0000 + 32'(i), 32'h0f0f_1234 ^ 32'(i)});
    end
    for (int i = 0; i < 6; i++) begin
      host_op(8'h00, addr_w'(40 + 7 * i), '0);
    end
    wait_drain();
    end_test(3, "host write and read");

    host_op(8'hff, 10'd100, 64'h1111_2222_3333_4444);
    idle(20);
    debug_op(8'h00, 10'd100, '0);
    host_op(8'h0f, 10'd101, 64'haaaa_bbbb_cccc_dddd);
    idle(20);
    debug_op(8'h00, 10'd101, '0);
    debug_op(8'hff, 10'd900, 64'hfedc_ba98_7654_3210);
    idle(20);
    host_op(8'h00, 10'd900, '0);
    debug_op(8'hf0, 10'd901, 64'h5555_6666_7777_8888);
    idle(20);
    host_op(8'h00, 10'd901, '0);
    wait_drain();
    end_test(4, "cross-port visibility");

    random_ops(200);
    wait_drain();
    end_test(5, "random operations");

    valid_before = n_valid;
    host_op(8'h81, 10'd222, 64'h0102_0304_0506_0708);
    idle(def_host_latency + 4);
    if (n_valid != valid_before) begin
      $display("Error: host write produced a host_dout_valid pulse");
      n_err++;
    end
    if (n_valid != n_host_rd) begin
      $display("FAIL host_dout_valid count: expected %h, got %h", n_host_rd, n_valid);
      n_err++;
    end
    end_test(6, "no response to writes");

    $display("Done: %0d checks, %0d errors, %0d host reads, %0d host pulses",
             n_checks, n_err, n_host_rd, n_valid);
    if (n_err == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
